// File: frontend_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Data path and pc widths
`define FE_XLEN 64
`define FE_PC_W 32

`define FE_RESET_PC 32'h0000_1000

// Queue depths
`define FE_FQ_DEPTH 2
`define FE_UOPQ_DEPTH 2

`endif

// File: frontend_pkg.sv
`include "frontend_params.svh"

package frontend_pkg;

    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    typedef struct packed {
        logic [31:0]          instr;
        logic [`FE_PC_W-1:0]  pc;
    } t_instr_pkt;

    typedef enum logic [2:0] {
        RV_FMT_R, RV_FMT_I, RV_FMT_S, RV_FMT_B, RV_FMT_U, RV_FMT_J, RV_FMT_NONE
    } t_ifmt;

    typedef enum logic [1:0] {OP_REG, OP_IMM, OP_ZERO, OP_INVD} t_optype;

    typedef enum logic {SZ_4B, SZ_8B} t_opsize;

    typedef struct packed {
        logic [4:0] opreg;
        t_optype    optype;
        t_opsize    opsize;
    } t_operand;

    typedef enum logic [4:0] {
        U_ADD, U_SUB, U_AND, U_OR, U_XOR, U_SLL, U_SRL, U_SRA, U_SLT, U_SLTU,
        U_LOAD, U_STORE, U_BRANCH, U_JAL, U_JALR, U_LUI, U_AUIPC, U_EBREAK, U_INVALID
    } t_uop;

    typedef struct packed {
        logic                 valid;
        logic [`FE_PC_W-1:0]  pc;
        logic [6:0]           opcode;
        t_ifmt                ifmt;
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        t_operand             dst;
        t_operand             src1;
        t_operand             src2;
        logic [`FE_XLEN-1:0]  imm64;
        t_uop                 uop;
    } t_uinstr;

    typedef struct packed {
        logic                 valid;
        logic [`FE_PC_W-1:0]  pc;
    } t_nuke_pkt;

    // Integer ops, register and immediate forms
    function automatic logic opcode_is_alu(logic [31:0] instr);
        return instr[6:0] inside {OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32};
    endfunction

    function automatic logic opcode_is_ld(logic [31:0] instr);
        return instr[6:0] == OPC_LOAD;
    endfunction

    function automatic logic opcode_is_st(logic [31:0] instr);
        return instr[6:0] == OPC_STORE;
    endfunction

    function automatic t_ifmt get_instr_format(logic [31:0] instr);
        case (instr[6:0])
            OPC_OP, OPC_OP_32: return RV_FMT_R;
            OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: return RV_FMT_I;
            OPC_STORE: return RV_FMT_S;
            OPC_BRANCH: return RV_FMT_B;
            OPC_LUI, OPC_AUIPC: return RV_FMT_U;
            OPC_JAL: return RV_FMT_J;
            default: return (instr == INSTR_EBREAK) ? RV_FMT_I : RV_FMT_NONE;
        endcase
    endfunction

    function automatic t_uop rv_instr_to_uop(logic [31:0] instr);
        logic [6:0] opc;
        logic       alt;
        opc = instr[6:0];
        alt = instr[30];
        if (opcode_is_alu(instr)) begin
            case (instr[14:12])
                // Only register forms have SUB
                3'b000: return (alt && opc[5]) ? U_SUB : U_ADD;
                3'b001: return U_SLL;
                3'b010: return U_SLT;
                3'b011: return U_SLTU;
                3'b100: return U_XOR;
                3'b101: return alt ? U_SRA : U_SRL;
                3'b110: return U_OR;
                default: return U_AND;
            endcase
        end
        case (opc)
            OPC_LOAD: return U_LOAD;
            OPC_STORE: return U_STORE;
            OPC_BRANCH: return U_BRANCH;
            OPC_JAL: return U_JAL;
            OPC_JALR: return U_JALR;
            OPC_LUI: return U_LUI;
            OPC_AUIPC: return U_AUIPC;
            default: return (instr == INSTR_EBREAK) ? U_EBREAK : U_INVALID;
        endcase
    endfunction

endpackage

// File: uop_fifo.sv
`timescale 1ns/100ps

module uop_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic push,
    input  T     din,
    output logic full,
    input  logic pop,
    output logic valid,
    output T     dout
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = count == CNT_W'(DEPTH);
    assign valid = count != '0;
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    no_overflow_a: assert property (@(posedge clk) disable iff (reset) push |-> !full);
    no_underflow_a: assert property (@(posedge clk) disable iff (reset) pop |-> valid);

endmodule

// File: fetch.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  frontend_pkg::t_nuke_pkt  nuke,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`FE_PC_W-1:0]      wb_adr,
    input  logic [31:0]              wb_dat_in,
    input  logic                     wb_ack,
    output logic                     fetch_valid,
    output frontend_pkg::t_instr_pkt fetch_pkt,
    input  logic                     decode_ready
);

    logic [`FE_PC_W-1:0]      pc;
    logic [`FE_PC_W-1:0]      req_adr;
    logic                     pending;
    logic                     stale;
    logic                     fq_full;
    logic                     fq_push;
    frontend_pkg::t_instr_pkt fq_din;

    assign wb_cyc = pending;
    assign wb_stb = pending;
    assign wb_we  = 1'b0;
    assign wb_adr = req_adr;

    // Data of a transfer that straddled a nuke is dropped
    assign fq_push = pending && wb_ack && !stale && !nuke.valid;
    assign fq_din  = '{instr: wb_dat_in, pc: req_adr};

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            stale   <= 1'b0;
            pc      <= `FE_RESET_PC;
        end else begin
            if (pending) begin
                if (wb_ack) begin
                    pending <= 1'b0;
                    stale   <= 1'b0;
                end else if (nuke.valid) begin
                    stale <= 1'b1;
                end
            end else if (!fq_full && !nuke.valid) begin
                pending <= 1'b1;
            end
            if (nuke.valid) begin
                pc <= nuke.pc;
            end else if (fq_push) begin
                pc <= pc + `FE_PC_W'(4);
            end
        end
    end

    // Address only moves while idle
    always_ff @(posedge clk) begin
        if (!pending) begin
            req_adr <= pc;
        end
    end

    uop_fifo #(
        .T     (frontend_pkg::t_instr_pkt),
        .DEPTH (`FE_FQ_DEPTH)
    ) fetch_queue (
        .clk   (clk),
        .reset (reset),
        .flush (nuke.valid),
        .push  (fq_push),
        .din   (fq_din),
        .full  (fq_full),
        .pop   (fetch_valid && decode_ready),
        .valid (fetch_valid),
        .dout  (fetch_pkt)
    );

    wb_hold_a: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

// File: decode.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module decode (
    input  logic                     clk,
    input  logic                     reset,
    input  frontend_pkg::t_nuke_pkt  nuke,
    input  logic                     fetch_valid,
    input  frontend_pkg::t_instr_pkt fetch_pkt,
    output logic                     decode_ready,
    input  logic                     rename_ready,
    output logic                     uop_valid,
    output frontend_pkg::t_uinstr    uinstr
);

    logic [31:0]           w;
    frontend_pkg::t_ifmt   ifmt;
    frontend_pkg::t_uop    uop_d;
    frontend_pkg::t_opsize alu_sz;
    frontend_pkg::t_uinstr uinstr_d;
    logic [`FE_XLEN-1:0]   imm_i;
    logic                  ebreak_seen;
    logic                  push;
    logic                  uopq_full;

    assign w      = fetch_pkt.instr;
    assign ifmt   = frontend_pkg::get_instr_format(w);
    assign uop_d  = frontend_pkg::rv_instr_to_uop(w);
    // W forms have opcode bit 3 set
    assign alu_sz = w[3] ? frontend_pkg::SZ_4B : frontend_pkg::SZ_8B;
    assign imm_i  = {{(`FE_XLEN - 12){w[31]}}, w[31:20]};

    always_comb begin
        uinstr_d        = '0;
        uinstr_d.valid  = fetch_valid;
        uinstr_d.pc     = fetch_pkt.pc;
        uinstr_d.opcode = w[6:0];
        uinstr_d.ifmt   = ifmt;
        uinstr_d.uop    = uop_d;
        uinstr_d.dst    = '{5'd0, frontend_pkg::OP_INVD, frontend_pkg::SZ_4B};
        uinstr_d.src1   = uinstr_d.dst;
        uinstr_d.src2   = uinstr_d.dst;

        case (ifmt)
            frontend_pkg::RV_FMT_R: begin
                uinstr_d.funct7 = w[31:25];
                uinstr_d.funct3 = w[14:12];
                uinstr_d.dst    = '{w[11:7], frontend_pkg::OP_REG, alu_sz};
                uinstr_d.src1   = '{w[19:15], frontend_pkg::OP_REG, alu_sz};
                uinstr_d.src2   = '{w[24:20], frontend_pkg::OP_REG, alu_sz};
            end
            frontend_pkg::RV_FMT_I: begin
                uinstr_d.funct3 = w[14:12];
                if (frontend_pkg::opcode_is_alu(w)) begin
                    uinstr_d.dst   = '{w[11:7], frontend_pkg::OP_REG, alu_sz};
                    uinstr_d.src1  = '{w[19:15], frontend_pkg::OP_REG, alu_sz};
                    uinstr_d.src2  = '{5'd0, frontend_pkg::OP_IMM, alu_sz};
                    uinstr_d.imm64 = imm_i;
                end else if (frontend_pkg::opcode_is_ld(w) || uop_d == frontend_pkg::U_JALR) begin
                    uinstr_d.dst   = '{w[11:7], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                    uinstr_d.src1  = '{w[19:15], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                    uinstr_d.src2  = '{5'd0, frontend_pkg::OP_IMM, frontend_pkg::SZ_4B};
                    uinstr_d.imm64 = imm_i;
                end
                // EBREAK keeps invalid operands
            end
            frontend_pkg::RV_FMT_S: begin
                uinstr_d.funct3 = w[14:12];
                if (frontend_pkg::opcode_is_st(w)) begin
                    uinstr_d.src1 = '{w[19:15], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                    uinstr_d.src2 = '{w[24:20], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                end
                uinstr_d.imm64 = {{(`FE_XLEN - 12){w[31]}}, w[31:25], w[11:7]};
            end
            frontend_pkg::RV_FMT_B: begin
                uinstr_d.funct3 = w[14:12];
                uinstr_d.src1   = '{w[19:15], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                uinstr_d.src2   = '{w[24:20], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                uinstr_d.imm64  = {{(`FE_XLEN - 13){w[31]}}, w[31], w[7], w[30:25],
                                   w[11:8], 1'b0};
            end
            frontend_pkg::RV_FMT_U: begin
                uinstr_d.dst   = '{w[11:7], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                uinstr_d.src2  = '{5'd0, frontend_pkg::OP_IMM, frontend_pkg::SZ_4B};
                uinstr_d.imm64 = {{(`FE_XLEN - 32){w[31]}}, w[31:12], 12'd0};
            end
            frontend_pkg::RV_FMT_J: begin
                uinstr_d.dst   = '{w[11:7], frontend_pkg::OP_REG, frontend_pkg::SZ_4B};
                uinstr_d.src2  = '{5'd0, frontend_pkg::OP_IMM, frontend_pkg::SZ_4B};
                uinstr_d.imm64 = {{(`FE_XLEN - 21){w[31]}}, w[31], w[19:12], w[20],
                                  w[30:21], 1'b0};
            end
            default: begin
            end
        endcase

        // x0 handling
        if (uinstr_d.src1.optype == frontend_pkg::OP_REG && uinstr_d.src1.opreg == 5'd0) begin
            uinstr_d.src1.optype = frontend_pkg::OP_ZERO;
        end
        if (uinstr_d.src2.optype == frontend_pkg::OP_REG && uinstr_d.src2.opreg == 5'd0) begin
            uinstr_d.src2.optype = frontend_pkg::OP_ZERO;
        end
        if (uinstr_d.dst.optype == frontend_pkg::OP_REG && uinstr_d.dst.opreg == 5'd0) begin
            uinstr_d.dst.optype = frontend_pkg::OP_INVD;
        end
    end

    // Accepted but dropped while the EBREAK hold is set
    assign push = fetch_valid && decode_ready && !ebreak_seen && !nuke.valid;

    always_ff @(posedge clk) begin
        if (reset || nuke.valid) begin
            ebreak_seen <= 1'b0;
        end else if (push && uop_d == frontend_pkg::U_EBREAK) begin
            ebreak_seen <= 1'b1;
        end
    end

    uop_fifo #(
        .T     (frontend_pkg::t_uinstr),
        .DEPTH (`FE_UOPQ_DEPTH)
    ) uop_queue (
        .clk   (clk),
        .reset (reset),
        .flush (nuke.valid),
        .push  (push),
        .din   (uinstr_d),
        .full  (uopq_full),
        .pop   (uop_valid && rename_ready),
        .valid (uop_valid),
        .dout  (uinstr)
    );

    assign decode_ready = !uopq_full;

    uop_quiet_in_reset_a: assert property (@(posedge clk) reset |=> !uop_valid);

endmodule

// File: frontend_top.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module frontend_top (
    input  logic                    clk,
    input  logic                    reset,
    input  frontend_pkg::t_nuke_pkt nuke,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`FE_PC_W-1:0]     wb_adr,
    input  logic [31:0]             wb_dat_in,
    input  logic                    wb_ack,
    input  logic                    rename_ready,
    output logic                    uop_valid,
    output frontend_pkg::t_uinstr   uinstr
);

    logic                     fetch_valid;
    logic                     decode_ready;
    frontend_pkg::t_instr_pkt fetch_pkt;

    fetch fetch0 (
        .clk          (clk),
        .reset        (reset),
        .nuke         (nuke),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_in    (wb_dat_in),
        .wb_ack       (wb_ack),
        .fetch_valid  (fetch_valid),
        .fetch_pkt    (fetch_pkt),
        .decode_ready (decode_ready)
    );

    decode decode0 (
        .clk          (clk),
        .reset        (reset),
        .nuke         (nuke),
        .fetch_valid  (fetch_valid),
        .fetch_pkt    (fetch_pkt),
        .decode_ready (decode_ready),
        .rename_ready (rename_ready),
        .uop_valid    (uop_valid),
        .uinstr       (uinstr)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tb_checker.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module tb_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  frontend_pkg::t_nuke_pkt nuke,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic                    rename_ready,
    input  logic                    uop_valid,
    input  frontend_pkg::t_uinstr   uinstr,
    output int                      consumed,
    output int                      field_errors,
    output int                      order_errors,
    output int                      bus_errors
);

    logic [31:0]           next_pc;
    logic                  after_ebreak;
    logic                  held_valid;
    frontend_pkg::t_uinstr held;

    function automatic frontend_pkg::t_operand reg_opnd(logic [4:0] r,
                                                        frontend_pkg::t_opsize sz,
                                                        logic is_dst);
        frontend_pkg::t_operand o;
        o.opreg  = r;
        o.opsize = sz;
        if (r != 5'd0) begin
            o.optype = frontend_pkg::OP_REG;
        end else begin
            o.optype = is_dst ? frontend_pkg::OP_INVD : frontend_pkg::OP_ZERO;
        end
        return o;
    endfunction

    function automatic frontend_pkg::t_operand fixed_opnd(frontend_pkg::t_optype t,
                                                          frontend_pkg::t_opsize sz);
        frontend_pkg::t_operand o;
        o.opreg  = 5'd0;
        o.optype = t;
        o.opsize = sz;
        return o;
    endfunction

    function automatic frontend_pkg::t_uop alu_op(logic [2:0] f3, logic b30, logic is_reg);
        case (f3)
            3'd0: return (is_reg && b30) ? frontend_pkg::U_SUB : frontend_pkg::U_ADD;
            3'd1: return frontend_pkg::U_SLL;
            3'd2: return frontend_pkg::U_SLT;
            3'd3: return frontend_pkg::U_SLTU;
            3'd4: return frontend_pkg::U_XOR;
            3'd5: return b30 ? frontend_pkg::U_SRA : frontend_pkg::U_SRL;
            3'd6: return frontend_pkg::U_OR;
            default: return frontend_pkg::U_AND;
        endcase
    endfunction

    // Reference decode of one table word
    function automatic frontend_pkg::t_uinstr model_decode(logic [31:0] pc, logic [31:0] w);
        frontend_pkg::t_uinstr u;
        frontend_pkg::t_opsize sz;
        frontend_pkg::t_operand none;
        logic [63:0] imm_i;
        none  = fixed_opnd(frontend_pkg::OP_INVD, frontend_pkg::SZ_4B);
        imm_i = {{(`FE_XLEN - 12){w[31]}}, w[31:20]};
        sz    = (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) ?
                frontend_pkg::SZ_8B : frontend_pkg::SZ_4B;
        u        = '0;
        u.valid  = 1'b1;
        u.pc     = pc;
        u.opcode = w[6:0];
        u.ifmt   = frontend_pkg::RV_FMT_NONE;
        u.uop    = frontend_pkg::U_INVALID;
        u.dst    = none;
        u.src1   = none;
        u.src2   = none;
        case (w[6:0])
            7'b0110011, 7'b0111011: begin
                u.ifmt   = frontend_pkg::RV_FMT_R;
                u.funct3 = w[14:12];
                u.funct7 = w[31:25];
                u.dst    = reg_opnd(w[11:7], sz, 1'b1);
                u.src1   = reg_opnd(w[19:15], sz, 1'b0);
                u.src2   = reg_opnd(w[24:20], sz, 1'b0);
                u.uop    = alu_op(w[14:12], w[30], 1'b1);
            end
            7'b0010011, 7'b0011011, 7'b0000011, 7'b1100111: begin
                // Loads and JALR are always 4 bytes
                if (w[6:0] == 7'b0000011 || w[6:0] == 7'b1100111) begin
                    sz = frontend_pkg::SZ_4B;
                end
                u.ifmt   = frontend_pkg::RV_FMT_I;
                u.funct3 = w[14:12];
                u.dst    = reg_opnd(w[11:7], sz, 1'b1);
                u.src1   = reg_opnd(w[19:15], sz, 1'b0);
                u.src2   = fixed_opnd(frontend_pkg::OP_IMM, sz);
                u.imm64  = imm_i;
                if (w[6:0] == 7'b0000011) begin
                    u.uop = frontend_pkg::U_LOAD;
                end else if (w[6:0] == 7'b1100111) begin
                    u.uop = frontend_pkg::U_JALR;
                end else begin
                    u.uop = alu_op(w[14:12], w[30], 1'b0);
                end
            end
            7'b0100011, 7'b1100011: begin
                u.funct3 = w[14:12];
                u.src1   = reg_opnd(w[19:15], frontend_pkg::SZ_4B, 1'b0);
                u.src2   = reg_opnd(w[24:20], frontend_pkg::SZ_4B, 1'b0);
                if (w[6:0] == 7'b0100011) begin
                    u.ifmt  = frontend_pkg::RV_FMT_S;
                    u.uop   = frontend_pkg::U_STORE;
                    u.imm64 = {{(`FE_XLEN - 12){w[31]}}, w[31:25], w[11:7]};
                end else begin
                    u.ifmt  = frontend_pkg::RV_FMT_B;
                    u.uop   = frontend_pkg::U_BRANCH;
                    u.imm64 = {{(`FE_XLEN - 13){w[31]}}, w[31], w[7], w[30:25],
                               w[11:8], 1'b0};
                end
            end
            7'b0110111, 7'b0010111, 7'b1101111: begin
                u.dst  = reg_opnd(w[11:7], frontend_pkg::SZ_4B, 1'b1);
                u.src2 = fixed_opnd(frontend_pkg::OP_IMM, frontend_pkg::SZ_4B);
                if (w[6:0] == 7'b1101111) begin
                    u.ifmt  = frontend_pkg::RV_FMT_J;
                    u.uop   = frontend_pkg::U_JAL;
                    u.imm64 = {{(`FE_XLEN - 21){w[31]}}, w[31], w[19:12], w[20],
                               w[30:21], 1'b0};
                end else begin
                    u.ifmt  = frontend_pkg::RV_FMT_U;
                    u.uop   = w[5] ? frontend_pkg::U_LUI : frontend_pkg::U_AUIPC;
                    u.imm64 = {{(`FE_XLEN - 32){w[31]}}, w[31:12], 12'h000};
                end
            end
            default: begin
                if (w == 32'h0010_0073) begin
                    u.ifmt = frontend_pkg::RV_FMT_I;
                    u.uop  = frontend_pkg::U_EBREAK;
                end
            end
        endcase
        return u;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            field_errors++;
            $display("Error at %0d ns: uinstr.%s expected %h, actual %h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_consumed();
        logic [31:0]           w;
        frontend_pkg::t_uinstr exp;
        w   = tb_frontend.imem[uinstr.pc[11:2]];
        exp = model_decode(uinstr.pc, w);
        if (uinstr.pc !== next_pc) begin
            order_errors++;
            $display("Error at %0d ns: uinstr.pc expected %h, actual %h",
                     $time, next_pc, uinstr.pc);
        end
        check_field("valid", exp.valid, uinstr.valid);
        check_field("opcode", exp.opcode, uinstr.opcode);
        check_field("ifmt", exp.ifmt, uinstr.ifmt);
        check_field("funct3", exp.funct3, uinstr.funct3);
        check_field("funct7", exp.funct7, uinstr.funct7);
        check_field("dst", exp.dst, uinstr.dst);
        check_field("src1", exp.src1, uinstr.src1);
        check_field("src2", exp.src2, uinstr.src2);
        check_field("imm64", exp.imm64, uinstr.imm64);
        check_field("uop", exp.uop, uinstr.uop);
        if (w == 32'h0010_0073) begin
            after_ebreak = 1'b1;
        end
        // Resync on the pc actually seen
        next_pc = uinstr.pc + 32'd4;
        consumed++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            next_pc      = `FE_RESET_PC;
            after_ebreak = 1'b0;
            held_valid   = 1'b0;
            consumed     = 0;
            field_errors = 0;
            order_errors = 0;
            bus_errors   = 0;
        end else begin
            if (wb_cyc !== wb_stb) begin
                bus_errors++;
                $display("At %0d ns wb_cyc and wb_stb differ", $time);
            end
            if (wb_we !== 1'b0) begin
                bus_errors++;
                $display("Error at %0d ns: wb_we expected 0, actual %b", $time, wb_we);
            end
            if (after_ebreak && uop_valid) begin
                order_errors++;
                $display("A micro-instruction at pc %h appeared after an EBREAK with no nuke",
                         uinstr.pc);
            end
            if (held_valid && !uop_valid) begin
                order_errors++;
                $display("uop_valid dropped at %0d ns while rename_ready was low", $time);
            end else if (held_valid && uinstr !== held) begin
                field_errors++;
                $display("Error at %0d ns: uinstr (stalled) expected %h, actual %h",
                         $time, held, uinstr);
            end
            held_valid = uop_valid && !rename_ready && !nuke.valid;
            held       = uinstr;
            if (uop_valid && rename_ready) begin
                check_consumed();
            end
            if (nuke.valid) begin
                next_pc      = nuke.pc;
                after_ebreak = 1'b0;
            end
        end
    end

endmodule

// File: tb_frontend.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module tb_frontend;

    localparam int N_UOPS     = 3000;
    localparam int MAX_CYCLES = N_UOPS * 20;
    localparam logic [6:0] OPCODES [11] = '{
        7'b0000011, 7'b0100011, 7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011,
        7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011
    };

    logic                    clk;
    logic                    reset;
    frontend_pkg::t_nuke_pkt nuke;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`FE_PC_W-1:0]     wb_adr;
    logic [31:0]             wb_dat_in;
    logic                    wb_ack;
    logic                    rename_ready;
    logic                    uop_valid;
    frontend_pkg::t_uinstr   uinstr;

    logic [31:0] imem [1024];
    logic [31:0] lfsr;
    int          consumed;
    int          field_errors;
    int          order_errors;
    int          bus_errors;
    int          cycles;
    int          ack_wait;
    logic        timed_out;

    tb_clock #(.PERIOD(8.0), .RESET_CYCLES(10)) clock0 (.clk(clk), .reset(reset));

    frontend_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .nuke         (nuke),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_in    (wb_dat_in),
        .wb_ack       (wb_ack),
        .rename_ready (rename_ready),
        .uop_valid    (uop_valid),
        .uinstr       (uinstr)
    );

    tb_checker checker0 (
        .clk          (clk),
        .reset        (reset),
        .nuke         (nuke),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .rename_ready (rename_ready),
        .uop_valid    (uop_valid),
        .uinstr       (uinstr),
        .consumed     (consumed),
        .field_errors (field_errors),
        .order_errors (order_errors),
        .bus_errors   (bus_errors)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fill_table();
        logic [31:0] sel;
        logic [31:0] fields;
        logic [31:0] k;
        for (int i = 0; i < 1024; i++) begin
            draw(7, sel);
            draw(25, fields);
            if (sel < 4) begin
                imem[i] = 32'h0010_0073;
            end else if (sel < 8) begin
                // A few fence and system words, which are unsupported
                imem[i] = {fields[24:0], sel[0] ? 7'b0001111 : 7'b1110011};
            end else begin
                draw(4, k);
                imem[i] = {fields[24:0], OPCODES[k % 11]};
            end
        end
    endtask

    // Memory, rename and nuke stimulus, all on the falling edge
    task automatic drive_cycle();
        logic [31:0] v;
        nuke   = '0;
        wb_ack = 1'b0;
        draw(7, v);
        rename_ready = v < 90;
        draw(6, v);
        if (v == 0) begin
            draw(30, v);
            nuke.valid = 1'b1;
            nuke.pc    = {v[29:0], 2'b00};
        end
        if (wb_stb) begin
            if (ack_wait < 0) begin
                draw(8, v);
                ack_wait = v % 3;
            end
            if (ack_wait == 0) begin
                wb_ack    = 1'b1;
                wb_dat_in = imem[wb_adr[11:2]];
                ack_wait  = -1;
            end else begin
                ack_wait--;
            end
        end
    endtask

    initial begin
        nuke         = '0;
        wb_dat_in    = '0;
        wb_ack       = 1'b0;
        rename_ready = 1'b0;
        lfsr         = 32'h8b4b5f60;
        cycles       = 0;
        ack_wait     = -1;
        fill_table();
        wait (!reset);
        while (consumed < N_UOPS && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            drive_cycle();
        end
        timed_out = consumed < N_UOPS;
        if (timed_out) begin
            $display("Timeout: only %0d of %0d micro-instructions consumed in %0d cycles",
                     consumed, N_UOPS, cycles);
        end
        $display("Consumed %0d: %0d field errors, %0d order errors, %0d bus errors, %0d timeouts",
                 consumed, field_errors, order_errors, bus_errors, timed_out);
        if (timed_out || field_errors != 0 || order_errors != 0 || bus_errors != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
frontend_pkg.sv
uop_fifo.sv
fetch.sv
decode.sv
frontend_top.sv
tb_clock.sv
tb_checker.sv
tb_frontend.sv

// File: Bender.yml
package:
  name: rv64_frontend

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - frontend_pkg.sv
      - uop_fifo.sv
      - fetch.sv
      - decode.sv
      - frontend_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_checker.sv
      - tb_frontend.sv
